// File: common/cfr_pkg.sv
//********************************************************************
// shared types and defaults for the PC-CFR block
// sample, peak and weight-write structs plus the saturation helper
//********************************************************************

`default_nettype none

package cfr_pkg;

  // sample width of I and Q
  parameter int DATA_WIDTH = 16;
  // L1 magnitude needs one bit more than a component
  parameter int MAG_WIDTH = DATA_WIDTH + 1;

  // weight memory defaults, two words per pulse sample
  parameter int CPW_ADDR_WIDTH = 5;
  parameter int CPW_LEN = 2 ** (CPW_ADDR_WIDTH - 1);
  // weights are Q1.14
  parameter int CPW_FRAC = 14;

  // wide enough for any intermediate sum before saturation
  parameter int SAT_WIDTH = 2 * DATA_WIDTH + 2;

  typedef struct packed {
    logic signed [DATA_WIDTH-1:0] i;
    logic signed [DATA_WIDTH-1:0] q;
  } cfr_sample_t;

  typedef struct packed {
    cfr_sample_t value;
    logic        phase;
    logic        valid;
  } cfr_peak_t;

  typedef struct packed {
    logic                      en;
    logic [CPW_ADDR_WIDTH-1:0] addr;
    cfr_sample_t               data;
  } cfr_cpw_wr_t;

  // clamp a sign-extended value to the signed sample range
  function automatic logic signed [DATA_WIDTH-1:0] cfr_sat(
    input logic signed [SAT_WIDTH-1:0] x
  );
    if (&x[SAT_WIDTH-1:DATA_WIDTH-1] || ~|x[SAT_WIDTH-1:DATA_WIDTH-1]) begin
      return x[DATA_WIDTH-1:0];
    end
    return x[SAT_WIDTH-1] ? {1'b1, {(DATA_WIDTH - 1) {1'b0}}}
                          : {1'b0, {(DATA_WIDTH - 1) {1'b1}}};
  endfunction

endpackage

`default_nettype wire

// File: design/cfr_delay_line.sv
//********************************************************************
// fixed-depth register delay for any payload type
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

module cfr_delay_line #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 2
) (
  input  var logic     clk,
  input  var logic     rst,
  input  var payload_t din_i,
  output var payload_t dout_o
);

  payload_t pipe_q [DEPTH];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < DEPTH; k++) begin
        pipe_q[k] <= '0;
      end
    end else begin
      pipe_q[0] <= din_i;
      for (int k = 1; k < DEPTH; k++) begin
        pipe_q[k] <= pipe_q[k-1];
      end
    end
  end

  assign dout_o = pipe_q[DEPTH-1];

endmodule

`default_nettype wire

// File: design/peak_detect/cfr_peak_detect.sv
//********************************************************************
// peak detector: three-sample window on L1 magnitude
// emits the centre sample and its phase when it is a local maximum
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

module cfr_peak_detect
  import cfr_pkg::*;
(
  input  var logic                 clk,
  input  var logic                 rst,
  input  var cfr_sample_t          data_i,
  input  var logic                 data_valid_i,
  input  var logic [MAG_WIDTH-1:0] thresh_i,
  output var cfr_peak_t            peak_o
);

  // |i| + |q|, the most negative value maps to 2^(DATA_WIDTH-1)
  function automatic logic [MAG_WIDTH-1:0] l1_mag(input cfr_sample_t s);
    logic [DATA_WIDTH-1:0] abs_i;
    logic [DATA_WIDTH-1:0] abs_q;
    abs_i = s.i[DATA_WIDTH-1] ? DATA_WIDTH'(-s.i) : s.i;
    abs_q = s.q[DATA_WIDTH-1] ? DATA_WIDTH'(-s.q) : s.q;
    return MAG_WIDTH'(abs_i) + MAG_WIDTH'(abs_q);
  endfunction

  logic [MAG_WIDTH-1:0] mag_in;
  // window: incoming sample (n+1), centre (n) and left neighbour (n-1)
  cfr_sample_t          centre_q;
  logic [MAG_WIDTH-1:0] mag_centre_q;
  logic [MAG_WIDTH-1:0] mag_left_q;
  logic                 centre_vld_q;
  logic                 left_vld_q;
  logic                 is_peak;

  logic                 peak_valid_q;
  logic                 peak_phase_q;
  cfr_sample_t          peak_value_q;

  assign mag_in = l1_mag(data_i);

  assign is_peak = data_valid_i && centre_vld_q && left_vld_q &&
                   (mag_centre_q > thresh_i) &&
                   (mag_centre_q >= mag_left_q) &&
                   (mag_centre_q > mag_in);

  // window only moves on valid samples
  always_ff @(posedge clk) begin
    if (rst) begin
      centre_vld_q <= 1'b0;
      left_vld_q   <= 1'b0;
    end else if (data_valid_i) begin
      centre_vld_q <= 1'b1;
      left_vld_q   <= centre_vld_q;
    end
  end

  always_ff @(posedge clk) begin
    if (data_valid_i) begin
      centre_q     <= data_i;
      mag_centre_q <= mag_in;
      mag_left_q   <= mag_centre_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      peak_valid_q <= 1'b0;
    end else begin
      peak_valid_q <= is_peak;
    end
  end

  // phase set when the right neighbour is the larger one
  always_ff @(posedge clk) begin
    peak_value_q <= centre_q;
    peak_phase_q <= mag_in > mag_left_q;
  end

  assign peak_o = '{value: peak_value_q, phase: peak_phase_q, valid: peak_valid_q};

endmodule

`default_nettype wire

// File: design/cpg/cfr_cpw_ram.sv
//********************************************************************
// pulse weight memory, one write port and one read port
// read latency 2, output forced to zero when nothing was read
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

module cfr_cpw_ram
  import cfr_pkg::*;
#(
  parameter int CPW_ADDR_WIDTH = cfr_pkg::CPW_ADDR_WIDTH
) (
  input  var logic                      clk,
  input  var cfr_cpw_wr_t               wr_i,
  input  var logic                      rd_en_i,
  input  var logic [CPW_ADDR_WIDTH-1:0] rd_addr_i,
  output var cfr_sample_t               rd_data_o
);

  localparam int DEPTH = 2 ** CPW_ADDR_WIDTH;

  cfr_sample_t               mem [DEPTH];
  logic [CPW_ADDR_WIDTH-1:0] wr_addr;
  cfr_sample_t               rd_word_q;
  logic                      rd_en_q;

  assign wr_addr = CPW_ADDR_WIDTH'(wr_i.addr);

  always_ff @(posedge clk) begin
    if (wr_i.en) begin
      mem[wr_addr] <= wr_i.data;
    end
  end

  // array read stage
  always_ff @(posedge clk) begin
    rd_en_q <= rd_en_i;
    if (rd_en_i) begin
      rd_word_q <= mem[rd_addr_i];
    end
  end

  // output register, idle stages feed zero to the multiplier
  always_ff @(posedge clk) begin
    rd_data_o <= rd_en_q ? rd_word_q : '0;
  end

endmodule

`default_nettype wire

// File: design/cpg/cfr_cmult.sv
//********************************************************************
// two-stage complex multiplier
// partial products, then sum, arithmetic shift and saturation
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

module cfr_cmult
  import cfr_pkg::*;
#(
  parameter int CPW_FRAC = cfr_pkg::CPW_FRAC
) (
  input  var logic        clk,
  input  var logic        rst,
  input  var cfr_sample_t a_i,
  input  var cfr_sample_t b_i,
  output var cfr_sample_t p_o
);

  localparam int PROD_WIDTH = 2 * DATA_WIDTH;

  logic signed [PROD_WIDTH-1:0] pp_rr_q;
  logic signed [PROD_WIDTH-1:0] pp_ii_q;
  logic signed [PROD_WIDTH-1:0] pp_ri_q;
  logic signed [PROD_WIDTH-1:0] pp_ir_q;
  // one guard bit for the add/sub
  logic signed [PROD_WIDTH:0]   re_sum;
  logic signed [PROD_WIDTH:0]   im_sum;

  //******************************************************************
  // stage 1: partial products
  //******************************************************************
  always_ff @(posedge clk) begin
    if (rst) begin
      pp_rr_q <= '0;
      pp_ii_q <= '0;
      pp_ri_q <= '0;
      pp_ir_q <= '0;
    end else begin
      pp_rr_q <= a_i.i * b_i.i;
      pp_ii_q <= a_i.q * b_i.q;
      pp_ri_q <= a_i.i * b_i.q;
      pp_ir_q <= a_i.q * b_i.i;
    end
  end

  //******************************************************************
  // stage 2: combine, scale back to sample range
  //******************************************************************
  assign re_sum = pp_rr_q - pp_ii_q;
  assign im_sum = pp_ri_q + pp_ir_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      p_o <= '0;
    end else begin
      p_o.i <= cfr_sat(SAT_WIDTH'(re_sum >>> CPW_FRAC));
      p_o.q <= cfr_sat(SAT_WIDTH'(im_sum >>> CPW_FRAC));
    end
  end

endmodule

`default_nettype wire

// File: design/cpg/cfr_cpg.sv
//********************************************************************
// canceling pulse generator, one stage of the cascade
// accepts a peak when idle, forwards it when busy, and adds the
// scaled pulse onto the passing data with saturation
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

module cfr_cpg
  import cfr_pkg::*;
#(
  parameter int CPW_ADDR_WIDTH = cfr_pkg::CPW_ADDR_WIDTH,
  parameter int CPW_FRAC       = cfr_pkg::CPW_FRAC
) (
  input  var logic        clk,
  input  var logic        rst,
  input  var cfr_sample_t data_i,
  output var cfr_sample_t data_o,
  input  var cfr_peak_t   peak_i,
  output var cfr_peak_t   peak_o,
  input  var cfr_cpw_wr_t cpw_wr_i
);

  logic                      accept;
  logic                      forward;
  logic                      busy_q;
  // pulse sample index, one bit narrower than the memory address
  logic [CPW_ADDR_WIDTH-2:0] addr_q;
  logic                      phase_q;
  cfr_sample_t               held_q;
  cfr_sample_t               held_dly;

  logic                      rd_en;
  logic [CPW_ADDR_WIDTH-1:0] rd_addr;
  cfr_sample_t               weight;
  cfr_sample_t               delta;

  logic                      fwd_valid_q;
  logic                      fwd_phase_q;
  cfr_sample_t               fwd_value_q;

  logic signed [DATA_WIDTH:0] sum_i;
  logic signed [DATA_WIDTH:0] sum_q;

  assign accept  = peak_i.valid && !busy_q;
  assign forward = peak_i.valid && busy_q;

  //******************************************************************
  // accept logic and weight address sequence
  //******************************************************************
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q  <= 1'b0;
      addr_q  <= '0;
      phase_q <= 1'b0;
      held_q  <= '0;
    end else if (accept) begin
      busy_q  <= 1'b1;
      addr_q  <= '0;
      phase_q <= peak_i.phase;
      held_q  <= peak_i.value;
    end else if (busy_q) begin
      // counter wraps back to zero after the last word
      addr_q <= addr_q + 1'b1;
      if (&addr_q) begin
        busy_q <= 1'b0;
        held_q <= '0;
      end
    end
  end

  // even words for phase 1, odd words for phase 0
  assign rd_en   = busy_q;
  assign rd_addr = {addr_q, ~phase_q};

  //******************************************************************
  // forward path for peaks arriving while busy
  //******************************************************************
  always_ff @(posedge clk) begin
    if (rst) begin
      fwd_valid_q <= 1'b0;
    end else begin
      fwd_valid_q <= forward;
    end
  end

  always_ff @(posedge clk) begin
    fwd_value_q <= forward ? peak_i.value : '0;
    fwd_phase_q <= forward ? peak_i.phase : 1'b0;
  end

  assign peak_o = '{value: fwd_value_q, phase: fwd_phase_q, valid: fwd_valid_q};

  cfr_cpw_ram #(
    .CPW_ADDR_WIDTH(CPW_ADDR_WIDTH)
  ) u_cfr_cpw_ram (
    .clk      (clk),
    .wr_i     (cpw_wr_i),
    .rd_en_i  (rd_en),
    .rd_addr_i(rd_addr),
    .rd_data_o(weight)
  );

  // match the two cycles of memory read latency
  cfr_delay_line #(
    .payload_t(cfr_sample_t),
    .DEPTH    (2)
  ) u_held_dly (
    .clk   (clk),
    .rst   (rst),
    .din_i (held_q),
    .dout_o(held_dly)
  );

  cfr_cmult #(
    .CPW_FRAC(CPW_FRAC)
  ) u_cfr_cmult (
    .clk(clk),
    .rst(rst),
    .a_i(held_dly),
    .b_i(weight),
    .p_o(delta)
  );

  // delta is zero outside a pulse, so this is a plain one-cycle delay then
  assign sum_i = data_i.i + delta.i;
  assign sum_q = data_i.q + delta.q;

  always_ff @(posedge clk) begin
    data_o.i <= cfr_sat(SAT_WIDTH'(sum_i));
    data_o.q <= cfr_sat(SAT_WIDTH'(sum_q));
  end

endmodule

`default_nettype wire

// File: design/cfr_top.sv
//********************************************************************
// PC-CFR top level
// peak detector, data delay line and a cascade of CPG stages
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

module cfr_top
  import cfr_pkg::*;
#(
  parameter int NUM_CPG        = 2,
  parameter int CPW_ADDR_WIDTH = cfr_pkg::CPW_ADDR_WIDTH,
  parameter int CPW_FRAC       = cfr_pkg::CPW_FRAC
) (
  input  var logic                 clk,
  input  var logic                 rst,
  input  var cfr_sample_t          data_i,
  input  var logic                 data_valid_i,
  input  var logic [MAG_WIDTH-1:0] thresh_i,
  input  var cfr_cpw_wr_t          cpw_wr_i,
  output var cfr_sample_t          data_o,
  output var logic                 data_valid_o,
  output var logic                 peak_drop_o
);

  localparam int PULSE_LEN  = 2 ** (CPW_ADDR_WIDTH - 1);
  // puts the detected sample at the centre of its pulse in stage 0
  localparam int DATA_DELAY = 7 + PULSE_LEN / 2;

  typedef struct packed {
    cfr_sample_t sample;
    logic        valid;
  } stream_t;

  stream_t     stream_in;
  stream_t     stream_dly;
  cfr_sample_t data_stage  [NUM_CPG+1];
  logic        valid_stage [NUM_CPG+1];
  cfr_peak_t   peak_stage  [NUM_CPG+1];

  assign stream_in = '{sample: data_i, valid: data_valid_i};

  cfr_peak_detect u_cfr_peak_detect (
    .clk         (clk),
    .rst         (rst),
    .data_i      (data_i),
    .data_valid_i(data_valid_i),
    .thresh_i    (thresh_i),
    .peak_o      (peak_stage[0])
  );

  cfr_delay_line #(
    .payload_t(stream_t),
    .DEPTH    (DATA_DELAY)
  ) u_data_dly (
    .clk   (clk),
    .rst   (rst),
    .din_i (stream_in),
    .dout_o(stream_dly)
  );

  assign data_stage[0]  = stream_dly.sample;
  assign valid_stage[0] = stream_dly.valid;

  for (genvar j = 0; j < NUM_CPG; j++) begin : g_cpg
    cfr_cpg #(
      .CPW_ADDR_WIDTH(CPW_ADDR_WIDTH),
      .CPW_FRAC      (CPW_FRAC)
    ) u_cfr_cpg (
      .clk     (clk),
      .rst     (rst),
      .data_i  (data_stage[j]),
      .data_o  (data_stage[j+1]),
      .peak_i  (peak_stage[j]),
      .peak_o  (peak_stage[j+1]),
      .cpw_wr_i(cpw_wr_i)
    );

    // valid follows the one-cycle data register of each stage
    always_ff @(posedge clk) begin
      if (rst) begin
        valid_stage[j+1] <= 1'b0;
      end else begin
        valid_stage[j+1] <= valid_stage[j];
      end
    end
  end

  assign data_o       = data_stage[NUM_CPG];
  assign data_valid_o = valid_stage[NUM_CPG];
  // a peak leaving the last stage found no free generator
  assign peak_drop_o  = peak_stage[NUM_CPG].valid;

endmodule

`default_nettype wire

// File: tb/cfr_clk_gen.sv
//********************************************************************
// testbench clock and synchronous reset source
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

module cfr_clk_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 2
) (
  output var logic clk_o,
  output var logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // release reset just after an edge, like the other inputs
  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    #2;
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

// File: tb/cfr_checker.sv
//********************************************************************
// assertions on one CPG stage
// forward only while busy, quiet after reset, accept xor forward
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

module cfr_checker
  import cfr_pkg::*;
(
  input var logic      clk,
  input var logic      rst,
  input var cfr_peak_t peak_in_i,
  input var cfr_peak_t peak_out_i,
  input var logic      busy_i
);

  // a forwarded peak arrived one cycle earlier at a busy stage
  assert property (@(posedge clk) disable iff (rst)
    peak_out_i.valid |-> $past(peak_in_i.valid && busy_i))
    else $error("cpg forwarded a peak that did not meet a busy stage");

  assert property (@(posedge clk)
    rst |=> !peak_out_i.valid)
    else $error("cpg peak output valid right after reset");

  // an accepted peak makes the stage busy and is not forwarded as well
  assert property (@(posedge clk) disable iff (rst)
    (peak_in_i.valid && !busy_i) |=> (busy_i && !peak_out_i.valid))
    else $error("cpg did not take an accepted peak or also forwarded it");

endmodule

`default_nettype wire

// File: tb/cfr_tb.sv
//********************************************************************
// testbench for the PC-CFR top level
// weight load, six stimulus sets, reference model and comparison
//********************************************************************

`timescale 1ns/1ps
`default_nettype none

module cfr_tb
  import cfr_pkg::*;
();

  localparam int NUM_CPG     = 2;
  localparam int ADDR_W      = 5;
  localparam int FRAC        = 14;
  localparam int WORDS       = 2 ** ADDR_W;
  localparam int PULSE_LEN   = WORDS / 2;
  localparam int LATENCY     = 7 + PULSE_LEN / 2 + NUM_CPG;
  localparam int LEAD        = 4;
  localparam int STIM_LEN    = LEAD + 40 + 32;
  localparam int NUM_TESTS   = 6;
  localparam int CYCLE_LIMIT = 2 + WORDS + NUM_TESTS * (STIM_LEN + LATENCY + 2) + 100;

  logic                 clk;
  logic                 rst;
  cfr_sample_t          data_i;
  logic                 data_valid_i;
  logic [MAG_WIDTH-1:0] thresh_i;
  cfr_cpw_wr_t          cpw_wr_i;
  cfr_sample_t          data_o;
  logic                 data_valid_o;
  logic                 peak_drop_o;

  cfr_sample_t stim     [STIM_LEN];
  cfr_sample_t exp_data [STIM_LEN];
  cfr_sample_t wtab     [WORDS];
  logic [31:0] lfsr_state = 32'd65774;
  string       cur_name;
  int          cur_thresh;
  int          out_idx;
  int          drop_cnt;
  int          test_errs;
  int          tests_passed;
  int          tests_failed;
  int          cycle_cnt;
  int          edge_cnt;
  int          start_cyc;

  cfr_clk_gen #(.PERIOD_NS(40), .RST_CYCLES(2)) u_cfr_clk_gen (.clk_o(clk), .rst_o(rst));

  cfr_top #(
    .NUM_CPG       (NUM_CPG),
    .CPW_ADDR_WIDTH(ADDR_W),
    .CPW_FRAC      (FRAC)
  ) u_cfr_top (
    .clk         (clk),
    .rst         (rst),
    .data_i      (data_i),
    .data_valid_i(data_valid_i),
    .thresh_i    (thresh_i),
    .cpw_wr_i    (cpw_wr_i),
    .data_o      (data_o),
    .data_valid_o(data_valid_o),
    .peak_drop_o (peak_drop_o)
  );

  bind cfr_cpg cfr_checker u_cfr_checker (
    .clk       (clk),
    .rst       (rst),
    .peak_in_i (peak_i),
    .peak_out_i(peak_o),
    .busy_i    (busy_q)
  );

  //******************************************************************
  // stimulus helpers
  //******************************************************************
  // right-shifting Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic int rand_bits(input int nbits);
    int r;
    r = 0;
    for (int b = 0; b < nbits; b++) begin
      r = (r << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
    end
    return r;
  endfunction

  function automatic cfr_sample_t make_sample(input int i, input int q);
    cfr_sample_t s;
    s.i = 16'(i);
    s.q = 16'(q);
    return s;
  endfunction

  // zeros around a body of small random samples
  function automatic void fill_random();
    for (int n = 0; n < STIM_LEN; n++) begin
      if (n < LEAD || n >= STIM_LEN - 32) begin
        stim[n] = make_sample(0, 0);
      end else begin
        stim[n] = make_sample(rand_bits(7) - 64, rand_bits(7) - 64);
      end
    end
  endfunction

  //******************************************************************
  // reference model
  //******************************************************************
  function automatic int clamp16(input longint x);
    if (x > 32767) return 32767;
    if (x < -32768) return -32768;
    return int'(x);
  endfunction

  function automatic int abs_int(input int x);
    return (x < 0) ? -x : x;
  endfunction

  // fills exp_data from stim and wtab, returns the number of dropped peaks
  function automatic int ref_model();
    int          mag [STIM_LEN];
    int          free_from [NUM_CPG];
    int          dlt_i [NUM_CPG][STIM_LEN];
    int          dlt_q [NUM_CPG][STIM_LEN];
    int          drops;
    int          stage;
    int          idx;
    int          mag_left;
    int          mag_right;
    int          phase;
    int          acc_i;
    int          acc_q;
    longint      re;
    longint      im;
    cfr_sample_t v;
    cfr_sample_t w;
    drops = 0;
    for (int n = 0; n < STIM_LEN; n++) begin
      mag[n] = abs_int(int'(stim[n].i)) + abs_int(int'(stim[n].q));
    end
    for (int s = 0; s < NUM_CPG; s++) begin
      free_from[s] = 0;
      for (int n = 0; n < STIM_LEN; n++) begin
        dlt_i[s][n] = 0;
        dlt_q[s][n] = 0;
      end
    end
    for (int n = 0; n < STIM_LEN; n++) begin
      mag_left  = (n > 0) ? mag[n-1] : 0;
      mag_right = (n < STIM_LEN - 1) ? mag[n+1] : 0;
      if (mag[n] > cur_thresh && mag[n] >= mag_left && mag[n] > mag_right) begin
        phase = (mag_right > mag_left) ? 1 : 0;
        stage = -1;
        // first idle stage takes the peak
        for (int s = 0; s < NUM_CPG && stage < 0; s++) begin
          if (n >= free_from[s]) stage = s;
        end
        if (stage < 0) begin
          drops++;
        end else begin
          free_from[stage] = n + PULSE_LEN + 1;
          v = stim[n];
          for (int k = 0; k < PULSE_LEN; k++) begin
            idx = n - PULSE_LEN / 2 + k;
            w = wtab[2 * k + 1 - phase];
            re = longint'(v.i) * w.i - longint'(v.q) * w.q;
            im = longint'(v.i) * w.q + longint'(v.q) * w.i;
            if (idx >= 0 && idx < STIM_LEN) begin
              dlt_i[stage][idx] = clamp16(re >>> FRAC);
              dlt_q[stage][idx] = clamp16(im >>> FRAC);
            end
          end
        end
      end
    end
    // stages add in cascade order, each one saturating
    for (int n = 0; n < STIM_LEN; n++) begin
      acc_i = stim[n].i;
      acc_q = stim[n].q;
      for (int s = 0; s < NUM_CPG; s++) begin
        acc_i = clamp16(longint'(acc_i) + dlt_i[s][n]);
        acc_q = clamp16(longint'(acc_q) + dlt_q[s][n]);
      end
      exp_data[n] = make_sample(acc_i, acc_q);
    end
    return drops;
  endfunction

  //******************************************************************
  // compare process, samples outputs at the rising edge
  //******************************************************************
  always @(posedge clk) begin
    if (!rst) begin
      if (peak_drop_o) drop_cnt++;
      if (data_valid_o) begin
        if (out_idx >= STIM_LEN) begin
          $display("%s: output sample %0d has no matching input", cur_name, out_idx);
          test_errs++;
        end else begin
          if (data_o !== exp_data[out_idx]) begin
            $display("ERR %s sample %0d: expected %h_%h actual %h_%h", cur_name, out_idx,
                     exp_data[out_idx].i, exp_data[out_idx].q, data_o.i, data_o.q);
            test_errs++;
          end
          // output cycle counted from the cycle the sample was driven
          if (edge_cnt - start_cyc - out_idx != LATENCY) begin
            $display("ERR %s sample %0d latency: expected %0d actual %0d", cur_name,
                     out_idx, LATENCY, edge_cnt - start_cyc - out_idx);
            test_errs++;
          end
        end
        out_idx++;
      end
    end
    edge_cnt++;
  end

  // runs one stimulus set, called 2 ns after a rising edge
  task automatic run_test(input string name, input int thr, input int want_drops);
    int exp_drops;
    cur_name   = name;
    cur_thresh = thr;
    thresh_i   = MAG_WIDTH'(thr);
    exp_drops  = ref_model();
    out_idx    = 0;
    drop_cnt   = 0;
    test_errs  = 0;
    if (exp_drops != want_drops) begin
      $display("%s: stimulus gives %0d drops in the model, not %0d", name, exp_drops,
               want_drops);
      test_errs++;
    end
    start_cyc = edge_cnt;
    for (int n = 0; n < STIM_LEN; n++) begin
      data_i       = stim[n];
      data_valid_i = 1'b1;
      @(posedge clk);
      #2;
    end
    data_valid_i = 1'b0;
    data_i       = make_sample(0, 0);
    while (out_idx < STIM_LEN) begin
      @(posedge clk);
      #2;
    end
    if (drop_cnt != exp_drops) begin
      $display("ERR %s peak_drop_o count: expected %0d actual %0d", name, exp_drops, drop_cnt);
      test_errs++;
    end
    $display("test %-12s %s, %0d mismatches", name, (test_errs == 0) ? "ok" : "failed",
             test_errs);
    if (test_errs == 0) tests_passed++;
    else tests_failed++;
  endtask

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: run still busy after %0d cycles", CYCLE_LIMIT);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    data_i       = make_sample(0, 0);
    data_valid_i = 1'b0;
    thresh_i     = '0;
    cpw_wr_i     = '0;
    out_idx      = 0;
    drop_cnt     = 0;
    test_errs    = 0;
    tests_passed = 0;
    tests_failed = 0;
    edge_cnt     = 0;
    start_cyc    = 0;
    cur_name     = "init";
    cur_thresh   = 0;
    // negative bell in I, small ramp in Q, odd words slightly stronger
    for (int a = 0; a < WORDS; a++) begin
      wtab[a] = make_sample(-(8192 - 800 * abs_int((a >> 1) - 8)) - 96 * (a & 1),
                            64 * ((a >> 1) - 8) + 32 * (a & 1) - 16);
    end
    wait (!rst);
    @(posedge clk);
    #2;
    for (int a = 0; a < WORDS; a++) begin
      cpw_wr_i = '{en: 1'b1, addr: 5'(a), data: wtab[a]};
      @(posedge clk);
      #2;
    end
    cpw_wr_i = '0;

    fill_random();
    run_test("below_thresh", 1000, 0);

    fill_random();
    stim[19] = make_sample(400, 0);
    stim[20] = make_sample(6000, -3000);
    stim[21] = make_sample(200, 0);
    run_test("phase0", 1000, 0);

    fill_random();
    stim[19] = make_sample(200, 0);
    stim[20] = make_sample(-5000, 4000);
    stim[21] = make_sample(400, 0);
    run_test("phase1", 1000, 0);

    fill_random();
    stim[16] = make_sample(5000, 2500);
    stim[24] = make_sample(-4000, 3000);
    run_test("two_peaks", 1000, 0);

    fill_random();
    stim[14] = make_sample(5000, 1000);
    stim[20] = make_sample(-3000, -4000);
    stim[26] = make_sample(4500, -2000);
    run_test("three_peaks", 1000, 1);

    // neighbours drive I to the low limit and Q to the high limit
    fill_random();
    stim[19] = make_sample(-30000, 30000);
    stim[20] = make_sample(32767, -32767);
    stim[21] = make_sample(-30000, 30000);
    run_test("saturation", 1000, 0);

    $display("%0d tests, %0d passed, %0d failed", NUM_TESTS, tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
common/cfr_pkg.sv
design/cfr_delay_line.sv
design/peak_detect/cfr_peak_detect.sv
design/cpg/cfr_cpw_ram.sv
design/cpg/cfr_cmult.sv
design/cpg/cfr_cpg.sv
design/cfr_top.sv
tb/cfr_clk_gen.sv
tb/cfr_checker.sv
tb/cfr_tb.sv

// File: Bender.yml
package:
  name: pc_cfr

sources:
  - files:
      - common/cfr_pkg.sv
      - design/cfr_delay_line.sv
      - design/peak_detect/cfr_peak_detect.sv
      - design/cpg/cfr_cpw_ram.sv
      - design/cpg/cfr_cmult.sv
      - design/cpg/cfr_cpg.sv
      - design/cfr_top.sv
  - target: test
    files:
      - tb/cfr_clk_gen.sv
      - tb/cfr_checker.sv
      - tb/cfr_tb.sv
